/* rtl/xr_mem_params.svh */
`ifndef XR_MEM_PARAMS_SVH
`define XR_MEM_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word and address geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XR_WIDTH      16
`define XR_NUMVBNK    4
`define XR_BITVBNK    2
`define XR_NUMVROW    16
`define XR_BITVROW    4
`define XR_BITADDR    (`XR_BITVBNK + `XR_BITVROW)

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ram timing and count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define XR_SRAM_DELAY 2
`define XR_NUMRAM     (`XR_NUMVBNK + 1)   // data banks + parity bank

`endif

/* rtl/xr_mem_pkg.sv */
`default_nettype none

`include "xr_mem_params.svh"

package xr_mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // datapath types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef logic [`XR_WIDTH-1:0]   word_t;
  typedef logic [`XR_BITADDR-1:0] addr_t;    // {row, bank}
  typedef logic [`XR_BITVROW-1:0] row_t;
  typedef logic [`XR_BITVBNK-1:0] bank_t;
  typedef logic [`XR_NUMRAM-1:0]  ram_sel_t; // msb is parity bank

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // controller states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef enum logic [1:0] {
    ST_INIT,       // zero sweep after reset
    ST_IDLE,
    ST_RMW_WAIT,   // old word and parity in flight
    ST_RMW_UPDATE  // write word and parity
  } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/bank_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xr_mem_params.svh"

module bank_ram (
  input  wire logic              clk,
  input  wire logic              rd,
  input  wire xr_mem_pkg::row_t  rd_row,
  input  wire logic              wr,
  input  wire xr_mem_pkg::row_t  wr_row,
  input  wire xr_mem_pkg::word_t wr_data,
  output xr_mem_pkg::word_t      rd_data
);
  import xr_mem_pkg::*;

  word_t mem [`XR_NUMVROW];
  word_t rd_pipe [`XR_SRAM_DELAY];

  // array write
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_row] <= wr_data;
    end
  end

  // read sampled before the same-edge write lands
  always_ff @(posedge clk) begin
    if (rd) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int i = 1; i < `XR_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];  // latency stages
    end
  end

  assign rd_data = rd_pipe[`XR_SRAM_DELAY-1];

endmodule

`default_nettype wire

/* rtl/xr_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xr_mem_params.svh"

module xr_ctrl (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              write,
  input  wire xr_mem_pkg::addr_t wr_adr,
  input  wire xr_mem_pkg::word_t din,
  input  wire logic [1:0]        read,
  input  wire xr_mem_pkg::addr_t rd_adr [2],
  input  wire xr_mem_pkg::word_t ram_dout [`XR_NUMRAM],
  output logic                   ready,
  output xr_mem_pkg::ram_sel_t   ram_rd,
  output xr_mem_pkg::row_t       ram_rd_row [`XR_NUMRAM],
  output xr_mem_pkg::ram_sel_t   ram_wr,
  output xr_mem_pkg::row_t       ram_wr_row,
  output xr_mem_pkg::word_t      ram_wr_data [`XR_NUMRAM],
  output logic [1:0]             issue_vld,
  output logic                   issue_conflict,
  output xr_mem_pkg::bank_t      issue_bank0,
  output xr_mem_pkg::bank_t      issue_bank1
);
  import xr_mem_pkg::*;

  localparam int PAR = `XR_NUMVBNK;  // parity ram index

  ctrl_state_e state;
  row_t        init_row;
  bank_t       wr_bank_q;
  row_t        wr_row_q;
  word_t       din_q;

  bank_t       wr_bank;
  row_t        wr_row;
  bank_t       rd_bank [2];
  row_t        rd_row [2];
  logic        conflict;
  word_t       new_parity;

  // low bits pick the bank, high bits the row
  assign wr_bank    = wr_adr[`XR_BITVBNK-1:0];
  assign wr_row     = wr_adr[`XR_BITADDR-1:`XR_BITVBNK];
  assign rd_bank[0] = rd_adr[0][`XR_BITVBNK-1:0];
  assign rd_row[0]  = rd_adr[0][`XR_BITADDR-1:`XR_BITVBNK];
  assign rd_bank[1] = rd_adr[1][`XR_BITVBNK-1:0];
  assign rd_row[1]  = rd_adr[1][`XR_BITADDR-1:`XR_BITVBNK];

  assign ready    = (state == ST_IDLE);
  assign conflict = read[0] && read[1] && (rd_bank[0] == rd_bank[1]);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state machine
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= ST_INIT;
      init_row <= '0;
    end else begin
      case (state)
        ST_INIT: begin
          init_row <= init_row + 1'b1;
          if (init_row == row_t'(`XR_NUMVROW - 1)) begin
            state <= ST_IDLE;  // sweep done
          end
        end
        ST_IDLE: begin
          if (write) begin
            state <= ST_RMW_WAIT;
          end
        end
        ST_RMW_WAIT:   state <= ST_RMW_UPDATE;
        ST_RMW_UPDATE: state <= ST_IDLE;
        default:       state <= ST_INIT;
      endcase
    end
  end

  // held write command
  always_ff @(posedge clk) begin
    if (ready && write) begin
      wr_bank_q <= wr_bank;
      wr_row_q  <= wr_row;
      din_q     <= din;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read port steering
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    ram_rd = '0;
    for (int i = 0; i < `XR_NUMRAM; i++) begin
      ram_rd_row[i] = rd_row[0];
    end
    if (ready && write) begin
      ram_rd[wr_bank]     = 1'b1;  // old word
      ram_rd[PAR]         = 1'b1;  // old parity
      ram_rd_row[wr_bank] = wr_row;
      ram_rd_row[PAR]     = wr_row;
    end else if (ready) begin
      if (read[1]) begin
        ram_rd[rd_bank[1]]     = 1'b1;
        ram_rd_row[rd_bank[1]] = rd_row[1];
      end
      if (conflict) begin
        // read 1 rebuilt from every other bank plus parity
        for (int i = 0; i < `XR_NUMRAM; i++) begin
          if (i != int'(rd_bank[0])) begin
            ram_rd[i]     = 1'b1;
            ram_rd_row[i] = rd_row[1];
          end
        end
      end
      if (read[0]) begin
        ram_rd[rd_bank[0]]     = 1'b1;  // read 0 always owns its bank
        ram_rd_row[rd_bank[0]] = rd_row[0];
      end
    end
  end

  assign issue_vld      = ready ? read : 2'b00;
  assign issue_conflict = ready && conflict;
  assign issue_bank0    = rd_bank[0];
  assign issue_bank1    = rd_bank[1];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign new_parity = ram_dout[PAR] ^ ram_dout[wr_bank_q] ^ din_q;

  always_comb begin
    ram_wr     = '0;
    ram_wr_row = init_row;
    for (int i = 0; i < `XR_NUMRAM; i++) begin
      ram_wr_data[i] = '0;  // zeros for the sweep
    end
    if (state == ST_INIT) begin
      ram_wr = '1;
    end else if (state == ST_RMW_UPDATE) begin
      ram_wr[wr_bank_q]      = 1'b1;
      ram_wr[PAR]            = 1'b1;
      ram_wr_row             = wr_row_q;
      ram_wr_data[wr_bank_q] = din_q;
      ram_wr_data[PAR]       = new_parity;
    end
  end

  a_no_cmd_busy: assert property (@(posedge clk) disable iff (reset)
    !ready |-> !write && (read == 2'b00));

  a_no_wr_with_rd: assert property (@(posedge clk) disable iff (reset)
    !(write && (|read)));

  a_wr_in_update: assert property (@(posedge clk) disable iff (reset)
    (|ram_wr) |-> (state == ST_INIT) || (state == ST_RMW_UPDATE));

endmodule

`default_nettype wire

/* rtl/xr_read_merge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xr_mem_params.svh"

module xr_read_merge (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic [1:0]        issue_vld,
  input  wire logic              issue_conflict,
  input  wire xr_mem_pkg::bank_t issue_bank0,
  input  wire xr_mem_pkg::bank_t issue_bank1,
  input  wire xr_mem_pkg::word_t ram_dout [`XR_NUMRAM],
  output logic [1:0]             rd_vld,
  output xr_mem_pkg::word_t      rd_dout [2]
);
  import xr_mem_pkg::*;

  localparam int LAST = `XR_SRAM_DELAY - 1;

  logic [1:0] vld_pipe [`XR_SRAM_DELAY];
  logic       conf_pipe [`XR_SRAM_DELAY];
  bank_t      bank0_pipe [`XR_SRAM_DELAY];
  bank_t      bank1_pipe [`XR_SRAM_DELAY];
  word_t      rebuild;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tag pipeline as deep as ram latency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `XR_SRAM_DELAY; i++) begin
        vld_pipe[i]  <= 2'b00;
        conf_pipe[i] <= 1'b0;
      end
    end else begin
      vld_pipe[0]  <= issue_vld;
      conf_pipe[0] <= issue_conflict;
      for (int i = 1; i < `XR_SRAM_DELAY; i++) begin
        vld_pipe[i]  <= vld_pipe[i-1];
        conf_pipe[i] <= conf_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    bank0_pipe[0] <= issue_bank0;
    bank1_pipe[0] <= issue_bank1;
    for (int i = 1; i < `XR_SRAM_DELAY; i++) begin
      bank0_pipe[i] <= bank0_pipe[i-1];
      bank1_pipe[i] <= bank1_pipe[i-1];
    end
  end

  // xor of parity and every bank but bank0
  always_comb begin
    rebuild = '0;
    for (int i = 0; i < `XR_NUMRAM; i++) begin
      if (i != int'(bank0_pipe[LAST])) begin
        rebuild = rebuild ^ ram_dout[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_vld <= 2'b00;
    end else begin
      rd_vld <= vld_pipe[LAST];
    end
  end

  always_ff @(posedge clk) begin
    rd_dout[0] <= ram_dout[bank0_pipe[LAST]];
    rd_dout[1] <= conf_pipe[LAST] ? rebuild : ram_dout[bank1_pipe[LAST]];
  end

  // conflict tag always carries both reads
  a_conflict_pair: assert property (@(posedge clk) disable iff (reset)
    issue_conflict |-> (issue_vld == 2'b11));

endmodule

`default_nettype wire

/* rtl/xr_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xr_mem_params.svh"

module xr_mem_top (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              write,
  input  wire xr_mem_pkg::addr_t wr_adr,
  input  wire xr_mem_pkg::word_t din,
  input  wire logic [1:0]        read,
  input  wire xr_mem_pkg::addr_t rd_adr [2],
  output logic                   ready,
  output logic [1:0]             rd_vld,
  output xr_mem_pkg::word_t      rd_dout [2]
);
  import xr_mem_pkg::*;

  ram_sel_t   ram_rd;
  row_t       ram_rd_row [`XR_NUMRAM];
  ram_sel_t   ram_wr;
  row_t       ram_wr_row;
  word_t      ram_wr_data [`XR_NUMRAM];
  word_t      ram_dout [`XR_NUMRAM];
  logic [1:0] issue_vld;
  logic       issue_conflict;
  bank_t      issue_bank0;
  bank_t      issue_bank1;

  xr_ctrl ctrl0 (
    .clk            (clk),
    .reset          (reset),
    .write          (write),
    .wr_adr         (wr_adr),
    .din            (din),
    .read           (read),
    .rd_adr         (rd_adr),
    .ram_dout       (ram_dout),
    .ready          (ready),
    .ram_rd         (ram_rd),
    .ram_rd_row     (ram_rd_row),
    .ram_wr         (ram_wr),
    .ram_wr_row     (ram_wr_row),
    .ram_wr_data    (ram_wr_data),
    .issue_vld      (issue_vld),
    .issue_conflict (issue_conflict),
    .issue_bank0    (issue_bank0),
    .issue_bank1    (issue_bank1)
  );

  // last index is the parity bank
  for (genvar i = 0; i < `XR_NUMRAM; i++) begin : bank_loop
    bank_ram ram (
      .clk     (clk),
      .rd      (ram_rd[i]),
      .rd_row  (ram_rd_row[i]),
      .wr      (ram_wr[i]),
      .wr_row  (ram_wr_row),
      .wr_data (ram_wr_data[i]),
      .rd_data (ram_dout[i])
    );
  end

  xr_read_merge merge0 (
    .clk            (clk),
    .reset          (reset),
    .issue_vld      (issue_vld),
    .issue_conflict (issue_conflict),
    .issue_bank0    (issue_bank0),
    .issue_bank1    (issue_bank1),
    .ram_dout       (ram_dout),
    .rd_vld         (rd_vld),
    .rd_dout        (rd_dout)
  );

endmodule

`default_nettype wire

/* tests/tb_xr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "xr_mem_params.svh"

module tb_xr_mem;
  import xr_mem_pkg::*;

  localparam int NADDR           = 1 << `XR_BITADDR;
  localparam int RD_LAT          = 2;     // rd_vld after edge k+2
  localparam int NUM_RANDOM      = 300;
  localparam int NUM_OPS         = 5 * NADDR + NUM_RANDOM;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 4 + `XR_NUMVROW + 50;
  localparam int EXP_DEPTH       = 1024;

  logic       clk = 1'b0;
  logic       reset;
  logic       write;
  addr_t      wr_adr;
  word_t      din;
  logic [1:0] read;
  addr_t      rd_adr [2];
  logic       ready;
  logic [1:0] rd_vld;
  word_t      rd_dout [2];

  word_t       model [NADDR];
  word_t       exp_q0 [EXP_DEPTH];   // fifo of expected words, port 0
  word_t       exp_q1 [EXP_DEPTH];
  int          head0 = 0;
  int          tail0 = 0;
  int          head1 = 0;
  int          tail1 = 0;
  logic [1:0]  vld_exp [RD_LAT+1];   // accepted reads, delayed
  int          busy_cnt = 0;
  logic        init_seen = 1'b0;
  int          wr_cnt = 0;
  int          error_cnt = 0;
  logic [31:0] rng_state = 32'h8c63_c797;

  always #5 clk = ~clk;

  xr_mem_top dut0 (
    .clk     (clk),
    .reset   (reset),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .ready   (ready),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic flag_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
    error_cnt++;
    $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
  endtask

  // return at an edge where the next edge accepts a command
  task automatic wait_slot();
    while (ready !== 1'b1 || write === 1'b1) begin
      write <= 1'b0;
      read  <= 2'b00;
      @(posedge clk);
    end
  endtask

  task automatic write_word(addr_t adr, word_t data);
    wait_slot();
    write  <= 1'b1;
    wr_adr <= adr;
    din    <= data;
    read   <= 2'b00;
    @(posedge clk);
  endtask

  task automatic read_words(logic [1:0] en, addr_t adr0, addr_t adr1);
    wait_slot();
    write     <= 1'b0;
    read      <= en;
    rd_adr[0] <= adr0;
    rd_adr[1] <= adr1;
    @(posedge clk);
  endtask

  task automatic go_idle(int cycles);
    repeat (cycles) begin
      write <= 1'b0;
      read  <= 2'b00;
      @(posedge clk);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i <= RD_LAT; i++) begin
        vld_exp[i] <= 2'b00;
      end
    end else begin
      vld_exp[0] <= (ready === 1'b1) ? read : 2'b00;
      for (int i = 1; i <= RD_LAT; i++) begin
        vld_exp[i] <= vld_exp[i-1];
      end
      if (ready === 1'b1 && write) begin
        model[wr_adr] <= din;  // visible at acceptance
        wr_cnt        <= wr_cnt + 1;
      end
      if (ready === 1'b1 && read[0]) begin
        exp_q0[tail0] <= model[rd_adr[0]];
        tail0         <= tail0 + 1;
      end
      if (ready === 1'b1 && read[1]) begin
        exp_q1[tail1] <= model[rd_adr[1]];
        tail1         <= tail1 + 1;
      end
      if (rd_vld[0]) head0 <= head0 + 1;
      if (rd_vld[1]) head1 <= head1 + 1;
    end
  end

  // length of each low stretch of ready
  always @(posedge clk) begin
    if (reset) begin
      busy_cnt  <= 0;
      init_seen <= 1'b0;
    end else if (ready === 1'b1) begin
      busy_cnt  <= 0;
      init_seen <= 1'b1;
    end else begin
      busy_cnt <= busy_cnt + 1;
    end
  end

  a_init_len: assert property (@(posedge clk) disable iff (reset)
    (ready && !init_seen) |-> (busy_cnt == `XR_NUMVROW))
    else flag_mismatch("ready low cycles after reset", `XR_NUMVROW, $sampled(busy_cnt));

  a_write_len: assert property (@(posedge clk) disable iff (reset)
    (ready && init_seen && busy_cnt != 0) |-> (busy_cnt == 2))
    else flag_mismatch("ready low cycles after write", 2, $sampled(busy_cnt));

  a_write_drop: assert property (@(posedge clk) disable iff (reset)
    (ready && write) |=> !ready)
    else begin
      error_cnt++;
      $display("t=%0t ready stayed high after an accepted write", $time);
    end

  a_rd_vld: assert property (@(posedge clk) disable iff (reset)
    rd_vld == vld_exp[RD_LAT])
    else flag_mismatch("rd_vld", $sampled(vld_exp[RD_LAT]), $sampled(rd_vld));

  a_rd0_data: assert property (@(posedge clk) disable iff (reset)
    rd_vld[0] |-> (rd_dout[0] == exp_q0[head0]))
    else flag_mismatch("rd_dout[0]", $sampled(exp_q0[head0]), $sampled(rd_dout[0]));

  a_rd1_data: assert property (@(posedge clk) disable iff (reset)
    rd_vld[1] |-> (rd_dout[1] == exp_q1[head1]))
    else flag_mismatch("rd_dout[1]", $sampled(exp_q1[head1]), $sampled(rd_dout[1]));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    logic [31:0] r;
    addr_t       a;
    addr_t       b;
    reset     = 1'b1;
    write     = 1'b0;
    wr_adr    = '0;
    din       = '0;
    read      = 2'b00;
    rd_adr[0] = '0;
    rd_adr[1] = '0;
    for (int i = 0; i < NADDR; i++) begin
      model[i] = '0;  // sweep clears everything
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    for (int i = 0; i < NADDR; i++) begin
      read_words(2'b11, addr_t'(i), addr_t'(NADDR - 1 - i));  // banks always differ
    end
    for (int i = 0; i < NADDR; i++) begin
      write_word(addr_t'(i), word_t'(next_rand()));
    end
    for (int i = 0; i < NADDR; i++) begin
      read_words(2'b11, addr_t'(NADDR - 1 - i), addr_t'(i));
    end
    // same bank, other row, then the very same address
    for (int i = 0; i < NADDR; i++) begin
      read_words(2'b11, addr_t'(i), addr_t'(i) ^ addr_t'(1 << `XR_BITVBNK));
      read_words(2'b11, addr_t'(i), addr_t'(i));
    end

    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = next_rand();
      a = addr_t'(r >> 8);
      b = addr_t'(r >> 16);
      case (r[1:0])
        2'd0: write_word(a, word_t'(next_rand()));
        2'd1: read_words(r[2] ? 2'b10 : 2'b01, a, b);
        default: begin
          if (r[4:3] != 2'b00) begin
            b[`XR_BITVBNK-1:0] = a[`XR_BITVBNK-1:0];  // mostly same bank
          end
          read_words(2'b11, a, b);
        end
      endcase
    end
    go_idle(RD_LAT + 4);

    a_drained: assert (head0 == tail0 && head1 == tail1)
      else begin
        error_cnt++;
        $display("read responses missing at end: port 0 got %0d of %0d, port 1 got %0d of %0d",
                 head0, tail0, head1, tail1);
      end

    $display("summary: %0d writes, %0d port 0 reads, %0d port 1 reads, %0d errors",
             wr_cnt, head0, head1, error_cnt);
    if (error_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+rtl
rtl/xr_mem_pkg.sv
rtl/bank_ram.sv
rtl/xr_ctrl.sv
rtl/xr_read_merge.sv
rtl/xr_mem_top.sv
tests/tb_xr_mem.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_xr_mem
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
